//--- dds_sweep.f
+incdir+design
+incdir+dv
design/dds_sweep_pkg.sv
design/profile_bus_if.sv
design/profile_loader.sv
design/profile_arbiter.sv
design/sweep_sequencer.sv
design/dds_serializer.sv
design/dds_sweep.sv
dv/dds_sweep_tb.sv

//--- design/dds_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module dds_serializer (
	input  logic                    SCLK_PE_3_1,
	input  logic                    arst_n,
	input  logic                    prof_valid,
	input  dds_sweep_pkg::profile_t prof,
	output logic                    credit_ret,
	output logic                    sclk,
	output logic                    sdio,
	output logic                    io_update,
	output logic                    dr_ctl
);
	import dds_sweep_pkg::*;

	localparam int BIT_W = $clog2(`PROFILE_BITS);
	localparam int PH_W  = $clog2((`IOUPD_GAP > `IOUPD_LEN) ? `IOUPD_GAP : `IOUPD_LEN);

	typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_GAP, ST_UPD} ser_state_t;

	ser_state_t       state_q;
	logic [BIT_W-1:0] bit_cnt_q;
	logic [PH_W-1:0]  phase_q;
	profile_t         cur_q;
	profile_t         pend_q;
	logic             pend_valid_q;
	logic             upd_done;
	logic             frame_free;
	logic             start;
	logic             pend_load;
	profile_t         start_data;

	assign upd_done   = (state_q == ST_UPD) && (phase_q == PH_W'(`IOUPD_LEN - 1));
	assign frame_free = (state_q == ST_IDLE) || upd_done;
	assign start      = frame_free && (pend_valid_q || prof_valid);
	assign start_data = pend_valid_q ? pend_q : prof;

	// a new profile skips the waiting slot only when nothing is queued ahead of it
	assign pend_load  = prof_valid && !(frame_free && !pend_valid_q);

	always_ff @(posedge SCLK_PE_3_1)
	begin
		if (start)
		begin
			cur_q <= start_data;
		end
		if (pend_load)
		begin
			pend_q <= prof;
		end
	end

	always_ff @(posedge SCLK_PE_3_1 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q      <= ST_IDLE;
			bit_cnt_q    <= '0;
			phase_q      <= '0;
			pend_valid_q <= 1'b0;
			credit_ret   <= 1'b0;
			sclk         <= 1'b0;
			sdio         <= 1'b0;
			io_update    <= 1'b0;
			dr_ctl       <= 1'b0;
		end
		else
		begin
			credit_ret <= 1'b0;
			if (pend_load)
			begin
				pend_valid_q <= 1'b1;
			end
			else if (start && pend_valid_q)
			begin
				pend_valid_q <= 1'b0;
			end
			case (state_q)
				ST_SHIFT:
				begin
					// sdio changes only on the falling half, so it is stable at each rise
					if (!sclk)
					begin
						sclk <= 1'b1;
					end
					else
					begin
						sclk <= 1'b0;
						if (bit_cnt_q == '0)
						begin
							sdio    <= 1'b0;
							phase_q <= '0;
							state_q <= ST_GAP;
						end
						else
						begin
							bit_cnt_q <= bit_cnt_q - 1'b1;
							sdio      <= cur_q[bit_cnt_q - 1'b1];
						end
					end
				end
				ST_GAP:
				begin
					if (phase_q == PH_W'(`IOUPD_GAP - 1))
					begin
						io_update <= 1'b1;
						phase_q   <= '0;
						state_q   <= ST_UPD;
						// equal words leave the ramp direction as it was
						if (cur_q.end_word > cur_q.start_word)
						begin
							dr_ctl <= 1'b1;
						end
						else if (cur_q.end_word < cur_q.start_word)
						begin
							dr_ctl <= 1'b0;
						end
					end
					else
					begin
						phase_q <= phase_q + 1'b1;
					end
				end
				ST_UPD:
				begin
					if (upd_done)
					begin
						io_update  <= 1'b0;
						credit_ret <= 1'b1;
						state_q    <= ST_IDLE;
					end
					else
					begin
						phase_q <= phase_q + 1'b1;
					end
				end
				default:
				begin
				end
			endcase
			if (start)
			begin
				state_q   <= ST_SHIFT;
				bit_cnt_q <= BIT_W'(`PROFILE_BITS - 1);
				sdio      <= start_data[`PROFILE_BITS-1];
				sclk      <= 1'b0;
			end
		end
	end

	// the sequencer's credits should keep it from overrunning both slots
	a_no_overrun: assert property (@(posedge SCLK_PE_3_1) disable iff (!arst_n)
		prof_valid |-> !((state_q != ST_IDLE) && pend_valid_q));

endmodule

`default_nettype wire

//--- design/dds_sweep.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module dds_sweep (
	input  logic SCLK_PE_3_1,
	input  logic arst_n,
	input  logic load_valid,
	input  logic load_bit,
	input  logic load_restart,
	input  logic key_n,
	output logic sclk,
	output logic sdio,
	output logic io_update,
	output logic dr_ctl
);
	import dds_sweep_pkg::*;

	profile_cnt_t profile_count;
	profile_t     prof;
	logic         prof_valid;
	logic         credit_ret;

	// loader writes and sequencer reads share the one profile memory
	profile_bus_if wr_bus ();
	profile_bus_if rd_bus ();

	profile_loader profile_loader_i (
		.SCLK_PE_3_1   (SCLK_PE_3_1),
		.arst_n        (arst_n),
		.load_valid    (load_valid),
		.load_bit      (load_bit),
		.load_restart  (load_restart),
		.profile_count (profile_count),
		.bus           (wr_bus.master)
	);

	profile_arbiter profile_arbiter_i (
		.SCLK_PE_3_1 (SCLK_PE_3_1),
		.arst_n      (arst_n),
		.wr_bus      (wr_bus.slave),
		.rd_bus      (rd_bus.slave)
	);

	sweep_sequencer sweep_sequencer_i (
		.SCLK_PE_3_1   (SCLK_PE_3_1),
		.arst_n        (arst_n),
		.key_n         (key_n),
		.load_restart  (load_restart),
		.profile_count (profile_count),
		.credit_ret    (credit_ret),
		.prof_valid    (prof_valid),
		.prof          (prof),
		.bus           (rd_bus.master)
	);

	dds_serializer dds_serializer_i (
		.SCLK_PE_3_1 (SCLK_PE_3_1),
		.arst_n      (arst_n),
		.prof_valid  (prof_valid),
		.prof        (prof),
		.credit_ret  (credit_ret),
		.sclk        (sclk),
		.sdio        (sdio),
		.io_update   (io_update),
		.dr_ctl      (dr_ctl)
	);

endmodule

`default_nettype wire

//--- design/dds_sweep_consts.svh
`ifndef DDS_SWEEP_CONSTS_SVH
`define DDS_SWEEP_CONSTS_SVH

// one profile is one DDS frame, address byte first
`define PROFILE_BITS 184

// number of profiles the memory can hold
`define PROFILE_DEPTH 20

// cycles after an accepted key press during which the key is ignored
`define HOLDOFF_CYCLES 64

// cycles from the last sclk fall to the rising edge of io_update
`define IOUPD_GAP 49

// io_update pulse width in cycles
`define IOUPD_LEN 5

// profile slots in the serializer, one shifting and one waiting
`define SER_CREDITS 2

`endif

//--- design/dds_sweep_pkg.sv
`default_nettype none

`include "dds_sweep_consts.svh"

package dds_sweep_pkg;

	// fields are listed in the order they go out on sdio
	typedef struct packed {
		logic [7:0]                 addr_byte;
		logic [31:0]                start_word;
		logic [31:0]                end_word;
		// step and rate words, not interpreted here
		logic [`PROFILE_BITS-73:0]  ramp_bits;
	} profile_t;

	typedef logic [$clog2(`PROFILE_DEPTH)-1:0]   profile_idx_t;

	// needs one more code than the index so a full memory can be counted
	typedef logic [$clog2(`PROFILE_DEPTH+1)-1:0] profile_cnt_t;

endpackage

`default_nettype wire

//--- design/profile_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module profile_arbiter (
	input  logic         SCLK_PE_3_1,
	input  logic         arst_n,
	profile_bus_if.slave wr_bus,
	profile_bus_if.slave rd_bus
);
	import dds_sweep_pkg::*;

	profile_t     mem [`PROFILE_DEPTH];
	profile_t     rdata_q;
	logic         wr_rvalid_q;
	logic         rd_rvalid_q;
	logic         wr_gnt;
	logic         rd_gnt;
	logic         sel_we;
	profile_idx_t sel_addr;
	profile_t     sel_wdata;

	// the loader always wins, the sequencer waits for a free cycle
	assign wr_gnt = wr_bus.req;
	assign rd_gnt = rd_bus.req && !wr_bus.req;

	assign wr_bus.gnt = wr_gnt;
	assign rd_bus.gnt = rd_gnt;

	always_comb
	begin
		if (wr_gnt)
		begin
			sel_we    = wr_bus.we;
			sel_addr  = wr_bus.addr;
			sel_wdata = wr_bus.wdata;
		end
		else
		begin
			sel_we    = rd_bus.we;
			sel_addr  = rd_bus.addr;
			sel_wdata = rd_bus.wdata;
		end
	end

	always_ff @(posedge SCLK_PE_3_1)
	begin
		if ((wr_gnt || rd_gnt) && sel_we)
		begin
			mem[sel_addr] <= sel_wdata;
		end
		if ((wr_gnt || rd_gnt) && !sel_we)
		begin
			rdata_q <= mem[sel_addr];
		end
	end

	// only one port is granted per cycle, so one read register serves both
	always_ff @(posedge SCLK_PE_3_1 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_rvalid_q <= 1'b0;
			rd_rvalid_q <= 1'b0;
		end
		else
		begin
			wr_rvalid_q <= wr_gnt && !wr_bus.we;
			rd_rvalid_q <= rd_gnt && !rd_bus.we;
		end
	end

	assign wr_bus.rdata  = rdata_q;
	assign wr_bus.rvalid = wr_rvalid_q;
	assign rd_bus.rdata  = rdata_q;
	assign rd_bus.rvalid = rd_rvalid_q;

	// a stalled read request has to stay up until it is granted
	a_rd_req_held: assert property (@(posedge SCLK_PE_3_1) disable iff (!arst_n)
		rd_bus.req && !rd_bus.gnt |=> rd_bus.req);

	// each master drops its request in the cycle after the grant
	a_req_drop: assert property (@(posedge SCLK_PE_3_1) disable iff (!arst_n)
		(wr_bus.gnt || rd_bus.gnt) |=> !(wr_bus.req && $past(wr_bus.gnt)) &&
		!(rd_bus.req && $past(rd_bus.gnt)));

endmodule

`default_nettype wire

//--- design/profile_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

interface profile_bus_if;
	import dds_sweep_pkg::*;

	// request side, held by the master until gnt
	logic         req;
	logic         we;
	profile_idx_t addr;
	profile_t     wdata;

	// response side, rdata and rvalid arrive one cycle after gnt on a read
	logic         gnt;
	profile_t     rdata;
	logic         rvalid;

	modport master (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport slave (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

`default_nettype wire

//--- design/profile_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module profile_loader (
	input  logic                        SCLK_PE_3_1,
	input  logic                        arst_n,
	input  logic                        load_valid,
	input  logic                        load_bit,
	input  logic                        load_restart,
	output dds_sweep_pkg::profile_cnt_t profile_count,
	profile_bus_if.master               bus
);
	import dds_sweep_pkg::*;

	localparam int BIT_W = $clog2(`PROFILE_BITS);

	logic [`PROFILE_BITS-1:0] shift_q;
	logic [BIT_W-1:0]         bit_cnt_q;
	logic                     req_q;
	profile_t                 wdata_q;
	logic                     last_bit;

	assign last_bit = load_valid && (bit_cnt_q == BIT_W'(`PROFILE_BITS - 1));

	// the write index is the number of profiles already stored
	assign bus.req   = req_q;
	assign bus.we    = 1'b1;
	assign bus.addr  = profile_idx_t'(profile_count);
	assign bus.wdata = wdata_q;

	// first bit received ends up as the struct msb
	always_ff @(posedge SCLK_PE_3_1)
	begin
		if (load_valid)
		begin
			shift_q <= {shift_q[`PROFILE_BITS-2:0], load_bit};
		end
		if (last_bit)
		begin
			wdata_q <= profile_t'({shift_q[`PROFILE_BITS-2:0], load_bit});
		end
	end

	always_ff @(posedge SCLK_PE_3_1 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt_q     <= '0;
			req_q         <= 1'b0;
			profile_count <= '0;
		end
		else if (load_restart)
		begin
			bit_cnt_q     <= '0;
			req_q         <= 1'b0;
			profile_count <= '0;
		end
		else
		begin
			if (last_bit)
			begin
				bit_cnt_q <= '0;
				// a full memory drops further profiles
				req_q     <= (profile_count < profile_cnt_t'(`PROFILE_DEPTH));
			end
			else if (load_valid)
			begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end
			if (req_q && bus.gnt)
			begin
				req_q         <= 1'b0;
				profile_count <= profile_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/sweep_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module sweep_sequencer (
	input  logic                        SCLK_PE_3_1,
	input  logic                        arst_n,
	input  logic                        key_n,
	input  logic                        load_restart,
	input  dds_sweep_pkg::profile_cnt_t profile_count,
	input  logic                        credit_ret,
	output logic                        prof_valid,
	output dds_sweep_pkg::profile_t     prof,
	profile_bus_if.master               bus
);
	import dds_sweep_pkg::*;

	localparam int HOLD_W = $clog2(`HOLDOFF_CYCLES + 1);
	localparam int CRED_W = $clog2(`SER_CREDITS + 1);

	typedef enum logic [1:0] {SQ_IDLE, SQ_REQ, SQ_DATA} seq_state_t;

	seq_state_t        state_q;
	logic [HOLD_W-1:0] holdoff_q;
	logic [CRED_W-1:0] credits_q;
	profile_idx_t      play_idx_q;
	profile_idx_t      next_idx;
	logic              key_accept;

	// a credit being spent this cycle is not yet visible in credits_q
	assign key_accept = !key_n && (holdoff_q == '0) && (profile_count != '0) &&
		(credits_q != '0) && !prof_valid;

	assign next_idx = play_idx_q + 1'b1;

	// read only, the address is stable until rvalid
	assign bus.req   = (state_q == SQ_REQ);
	assign bus.we    = 1'b0;
	assign bus.addr  = play_idx_q;
	assign bus.wdata = '0;

	always_ff @(posedge SCLK_PE_3_1)
	begin
		if ((state_q == SQ_DATA) && bus.rvalid)
		begin
			prof <= bus.rdata;
		end
	end

	always_ff @(posedge SCLK_PE_3_1 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q    <= SQ_IDLE;
			holdoff_q  <= '0;
			credits_q  <= CRED_W'(`SER_CREDITS);
			play_idx_q <= '0;
			prof_valid <= 1'b0;
		end
		else
		begin
			prof_valid <= 1'b0;
			if (holdoff_q != '0)
			begin
				holdoff_q <= holdoff_q - 1'b1;
			end
			case (state_q)
				SQ_IDLE:
				begin
					if (key_accept)
					begin
						state_q   <= SQ_REQ;
						holdoff_q <= HOLD_W'(`HOLDOFF_CYCLES);
					end
				end
				SQ_REQ:
				begin
					if (bus.gnt)
					begin
						state_q <= SQ_DATA;
					end
				end
				SQ_DATA:
				begin
					if (bus.rvalid)
					begin
						prof_valid <= 1'b1;
						state_q    <= SQ_IDLE;
						// wrap after the last loaded profile
						if (profile_cnt_t'(next_idx) >= profile_count)
						begin
							play_idx_q <= '0;
						end
						else
						begin
							play_idx_q <= next_idx;
						end
					end
				end
				default:
				begin
					state_q <= SQ_IDLE;
				end
			endcase
			if (load_restart)
			begin
				play_idx_q <= '0;
			end
			if (prof_valid && !credit_ret)
			begin
				credits_q <= credits_q - 1'b1;
			end
			else if (!prof_valid && credit_ret)
			begin
				credits_q <= credits_q + 1'b1;
			end
		end
	end

	// returns from the serializer must never outnumber what was spent
	a_credit_max: assert property (@(posedge SCLK_PE_3_1) disable iff (!arst_n)
		credits_q <= CRED_W'(`SER_CREDITS));

endmodule

`default_nettype wire

//--- dv/dds_sweep_tests.svh
`ifndef DDS_SWEEP_TESTS_SVH
`define DDS_SWEEP_TESTS_SVH

task automatic test_reset_state();
	int err_start;
	err_start = errors;
	check_value("sclk", frame_bits_t'(sclk), '0);
	check_value("sdio", frame_bits_t'(sdio), '0);
	check_value("io_update", frame_bits_t'(io_update), '0);
	check_value("dr_ctl", frame_bits_t'(dr_ctl), '0);
	// with nothing loaded the key must be ignored
	press_key();
	watch_quiet(500, "sclk rises with no profiles");
	finish_test("reset state", err_start);
endtask

task automatic test_frame_and_update();
	int err_start;
	err_start = errors;
	repeat (3)
	begin
		load_profile(random_profile());
	end
	play_and_check();
	finish_test("frame and update", err_start);
endtask

// after profile 0 the next three presses go 1, 2 and back to 0
task automatic test_wrap();
	int err_start;
	err_start = errors;
	repeat (3)
	begin
		play_and_check();
	end
	finish_test("wrap", err_start);
endtask

task automatic test_holdoff();
	int err_start;
	err_start = errors;
	press_key();
	// the second press lands while the first frame is already on sdio
	fork
		expect_frame(loaded[exp_idx]);
		begin
			idle_cycles(10);
			press_key();
		end
	join
	exp_idx = (exp_idx + 1) % loaded.size();
	// a second frame here would mean the second press got through
	watch_quiet(500, "sclk rises after hold-off press");
	finish_test("hold-off", err_start);
endtask

function automatic profile_t directional_profile(input int dir);
	profile_t    p;
	logic [31:0] base;
	p    = random_profile();
	base = $urandom() & 32'h7fff_ffff;
	if (dir > 0)
	begin
		p.start_word = base;
		p.end_word   = base + 32'h100;
	end
	else if (dir < 0)
	begin
		p.start_word = base + 32'h100;
		p.end_word   = base;
	end
	else
	begin
		p.start_word = base;
		p.end_word   = base;
	end
	return p;
endfunction

task automatic test_direction();
	int err_start;
	err_start = errors;
	restart_loader();
	load_profile(directional_profile(1));
	load_profile(directional_profile(-1));
	load_profile(directional_profile(0));
	play_and_check();
	check_value("dr_ctl after up sweep", frame_bits_t'(dr_ctl), frame_bits_t'(1));
	play_and_check();
	check_value("dr_ctl after down sweep", frame_bits_t'(dr_ctl), '0);
	// equal words leave the previous down direction in place
	play_and_check();
	check_value("dr_ctl after flat sweep", frame_bits_t'(dr_ctl), '0);
	finish_test("direction", err_start);
endtask

task automatic test_restart();
	int       err_start;
	profile_t fresh;
	err_start = errors;
	restart_loader();
	fresh = random_profile();
	load_profile(fresh);
	press_key();
	expect_frame(fresh);
	press_key();
	expect_frame(fresh);
	finish_test("restart", err_start);
endtask

`endif

//--- dv/dds_sweep_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_sweep_consts.svh"

module dds_sweep_tb;
	import dds_sweep_pkg::*;

	typedef logic [`PROFILE_BITS-1:0] frame_bits_t;

	// cycles allowed from a key press to the rise of io_update
	localparam int FRAME_TIMEOUT = 2 * `PROFILE_BITS + `IOUPD_GAP + 200;
	localparam int UPD_TIMEOUT   = 4 * `IOUPD_LEN;

	logic SCLK_PE_3_1;
	logic arst_n;
	logic load_valid;
	logic load_bit;
	logic load_restart;
	logic key_n;
	logic sclk;
	logic sdio;
	logic io_update;
	logic dr_ctl;

	int       errors;
	int       checks;
	int       tests_run;
	int       tests_failed;
	int       exp_idx;
	logic     exp_dr;
	profile_t loaded [$];

	dds_sweep dds_sweep_i (
		.SCLK_PE_3_1  (SCLK_PE_3_1),
		.arst_n       (arst_n),
		.load_valid   (load_valid),
		.load_bit     (load_bit),
		.load_restart (load_restart),
		.key_n        (key_n),
		.sclk         (sclk),
		.sdio         (sdio),
		.io_update    (io_update),
		.dr_ctl       (dr_ctl)
	);

	always #10 SCLK_PE_3_1 = ~SCLK_PE_3_1;

	task automatic check_value(input string name, input frame_bits_t got, input frame_bits_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t ns %s: expected %0h, got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("%0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge SCLK_PE_3_1);
	endtask

	function automatic profile_t random_profile();
		profile_t     p;
		logic [127:0] ramp;
		ramp         = {$urandom(), $urandom(), $urandom(), $urandom()};
		p.addr_byte  = 8'($urandom());
		p.start_word = $urandom();
		p.end_word   = $urandom();
		p.ramp_bits  = ramp[`PROFILE_BITS-73:0];
		return p;
	endfunction

	// the first bit sent is the msb of the struct
	task automatic load_profile(input profile_t p);
		for (int i = `PROFILE_BITS - 1; i >= 0; i--)
		begin
			@(posedge SCLK_PE_3_1);
			load_valid <= 1'b1;
			load_bit   <= p[i];
		end
		@(posedge SCLK_PE_3_1);
		load_valid <= 1'b0;
		load_bit   <= 1'b0;
		loaded.push_back(p);
		idle_cycles(3);
	endtask

	task automatic restart_loader();
		@(posedge SCLK_PE_3_1);
		load_restart <= 1'b1;
		@(posedge SCLK_PE_3_1);
		load_restart <= 1'b0;
		loaded.delete();
		exp_idx = 0;
		idle_cycles(2);
	endtask

	task automatic press_key();
		@(posedge SCLK_PE_3_1);
		key_n <= 1'b0;
		repeat (2) @(posedge SCLK_PE_3_1);
		key_n <= 1'b1;
	endtask

	// outputs change on the rising edge, so they are sampled on the falling one
	task automatic capture_frame(output frame_bits_t bits, output int nbits, output int upd_len,
		output bit ok);
		int   waited;
		logic prev_sclk;
		bits      = '0;
		nbits     = 0;
		upd_len   = 0;
		ok        = 1'b1;
		waited    = 0;
		prev_sclk = 1'b0;
		while (!io_update && waited < FRAME_TIMEOUT)
		begin
			@(negedge SCLK_PE_3_1);
			waited++;
			if (sclk && !prev_sclk)
			begin
				bits = {bits[`PROFILE_BITS-2:0], sdio};
				nbits++;
			end
			prev_sclk = sclk;
		end
		check_true(io_update, "timeout waiting for io_update after a key press");
		if (!io_update)
		begin
			ok = 1'b0;
		end
		else
		begin
			waited = 0;
			while (io_update && waited < UPD_TIMEOUT)
			begin
				upd_len++;
				@(negedge SCLK_PE_3_1);
				waited++;
			end
			check_true(!io_update, "timeout waiting for io_update to fall");
			ok = !io_update;
		end
	endtask

	task automatic watch_quiet(input int cycles, input string name);
		int   rises;
		logic prev_sclk;
		rises     = 0;
		prev_sclk = sclk;
		repeat (cycles)
		begin
			@(negedge SCLK_PE_3_1);
			if (sclk && !prev_sclk)
			begin
				rises++;
			end
			prev_sclk = sclk;
		end
		check_value(name, frame_bits_t'(rises), '0);
	endtask

	task automatic expect_frame(input profile_t exp);
		frame_bits_t bits;
		int          nbits;
		int          upd_len;
		bit          ok;
		capture_frame(bits, nbits, upd_len, ok);
		if (ok)
		begin
			check_value("frame bit count", frame_bits_t'(nbits), frame_bits_t'(`PROFILE_BITS));
			check_value("sdio frame", bits, exp);
			check_value("io_update width", frame_bits_t'(upd_len), frame_bits_t'(`IOUPD_LEN));
			// ramp direction follows the word order, equal words keep it
			if (exp.end_word > exp.start_word)
			begin
				exp_dr = 1'b1;
			end
			else if (exp.end_word < exp.start_word)
			begin
				exp_dr = 1'b0;
			end
			check_value("dr_ctl", frame_bits_t'(dr_ctl), frame_bits_t'(exp_dr));
		end
	endtask

	// the play index wraps after the last loaded profile
	task automatic play_and_check();
		press_key();
		expect_frame(loaded[exp_idx]);
		exp_idx = (exp_idx + 1) % loaded.size();
	endtask

	`include "dds_sweep_tests.svh"

	initial
	begin
		SCLK_PE_3_1  = 1'b0;
		arst_n       = 1'b0;
		load_valid   = 1'b0;
		load_bit     = 1'b0;
		load_restart = 1'b0;
		key_n        = 1'b1;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		exp_idx      = 0;
		exp_dr       = 1'b0;
		void'($urandom(32'hfa5edb87));
		repeat (8) @(posedge SCLK_PE_3_1);
		arst_n <= 1'b1;
		idle_cycles(4);
		test_reset_state();
		test_frame_and_update();
		test_wrap();
		test_holdoff();
		test_direction();
		test_restart();
		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dds_sweep_tb -f dds_sweep.f &&
./obj_dir/Vdds_sweep_tb | tee /dev/stderr | grep -x -F ">>> PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
